/* outputArbiter.f */
hdl/routerPkg.sv
hdl/requestTracker.sv
hdl/grantTimers.sv
hdl/grantArbiter.sv
hdl/outputArbiter.sv
tests/outputArbiter_properties.sv
tests/outputArbiter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the outputArbiter testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -j 0 \
  --top-module outputArbiter_tb \
  -f outputArbiter.f

simStatus=0
./obj_dir/VoutputArbiter_tb > "$LOG" 2>&1 || simStatus=$?
cat "$LOG"

if [ "$simStatus" -ne 0 ] || grep -q "TESTBENCH FAILED" "$LOG" \
  || ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"

/* tests/arbiter_trace.txt */
# columns: valid flitId length for ports L N E W S, then expected grant (all hex)
# expected grant is the grant right after the clock edge that takes in this line
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 1 007  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 3 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  1 1 004  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  1 3 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  1 1 002  0 0 000  1 1 001  1 1 003  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  1 3 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  1 3 000  0 0 000  0 0 000  1 3 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  1 1 028  00
0 0 000  0 0 000  0 0 000  0 0 000  1 2 002  10
1 1 001  0 0 000  1 1 003  0 0 000  0 0 000  10
1 2 00a  0 0 000  0 0 000  0 0 000  1 2 002  10
0 0 000  0 0 000  0 0 000  0 0 000  1 3 000  10
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  01
1 3 000  0 0 000  1 3 000  0 0 000  0 0 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  1 1 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  1 1 001  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  1 3 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  1 3 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
1 1 000  1 1 000  1 1 001  1 1 000  1 1 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  02
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  08
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
0 0 000  1 3 000  0 0 000  1 3 000  0 0 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  04
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  10
1 3 000  0 0 000  1 3 000  0 0 000  1 3 000  01
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00
0 0 000  0 0 000  0 0 000  0 0 000  0 0 000  00

/* tests/outputArbiter_tb.sv */
`timescale 1ns/1ps

module outputArbiter_tb;

  localparam int    RESET_CYCLES   = 16;
  localparam int    TIMEOUT_MARGIN = 20;
  localparam string TRACE_FILE     = "tests/arbiter_trace.txt";

  logic                                            clk;
  logic                                            rst;
  routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] portFlits;
  routerPkg::portVec_t                             grant;

  // one entry per trace line
  routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] traceFlits [$];
  routerPkg::portVec_t                             expGrants [$];

  int cycleCount   = 0;
  int timeoutLimit = 0;  // set once the trace is read

  outputArbiter outputArbiter_i
  (
    .clk       (clk),
    .rst       (rst),
    .portFlits (portFlits),
    .grant     (grant)
  );

  bind grantArbiter outputArbiter_props outputArbiter_props_i
  (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .timesUp (timesUp),
    .grant   (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkGrant(input routerPkg::portVec_t expected, input string where);
    assert (grant === expected)
    else
    begin
      $display("[FAIL] grant at %s: expected %h, got %h", where, expected, grant);
      abortRun();
    end
  endtask

  // each data line: valid, flitId, length for L N E W S, then expected grant
  task automatic readTrace();
    int                                              fd;
    int                                              fields;
    string                                           text;
    logic [31:0]                                     field [16];
    routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] flits;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the trace file %s", TRACE_FILE);
      abortRun();
    end
    while ($fgets(text, fd) != 0)
    begin
      if (text.len() < 2 || text.getc(0) == "#")
        continue;  // comment or blank line
      fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       field[0], field[1], field[2], field[3], field[4], field[5],
                       field[6], field[7], field[8], field[9], field[10], field[11],
                       field[12], field[13], field[14], field[15]);
      if (fields != 16)
      begin
        $display("trace line could not be parsed: %s", text);
        abortRun();
      end
      for (int p = 0; p < routerPkg::NUM_PORTS; p++)
      begin
        flits[p].valid  = field[3*p][0];
        flits[p].flitId = field[3*p+1][2:0];
        flits[p].length = field[3*p+2][11:0];
      end
      traceFlits.push_back(flits);
      expGrants.push_back(field[15][routerPkg::NUM_PORTS-1:0]);
    end
    $fclose(fd);
    if (traceFlits.size() == 0)
    begin
      $display("the trace file holds no stimulus lines");
      abortRun();
    end
  endtask

  // watchdog
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit != 0 && cycleCount >= timeoutLimit)
    begin
      $display("timeout after %0d cycles, the trace did not finish", cycleCount);
      abortRun();
    end
  end

  initial
  begin
    rst       = 1'b1;
    portFlits = '0;
    readTrace();
    timeoutLimit = traceFlits.size() + RESET_CYCLES + TIMEOUT_MARGIN;

    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
      @(negedge clk);
      checkGrant('0, "reset");
    end

    // expected grant of a line shows after the edge that samples it
    for (int i = 0; i < traceFlits.size(); i++)
    begin
      @(posedge clk);
      rst       <= 1'b0;
      portFlits <= traceFlits[i];
      @(negedge clk);
      if (i > 0)
        checkGrant(expGrants[i-1], $sformatf("trace line %0d", i - 1));
    end

    @(posedge clk);
    portFlits <= '0;
    @(negedge clk);
    checkGrant(expGrants[expGrants.size()-1],
               $sformatf("trace line %0d", expGrants.size() - 1));

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* tests/outputArbiter_properties.sv */
`timescale 1ns/1ps

module outputArbiter_props
(
  input logic                clk,
  input logic                rst,
  input routerPkg::portVec_t req,
  input routerPkg::portVec_t timesUp,
  input routerPkg::portVec_t grant
);

  // only one port may own the output at a time
  grantOneHot: assert property
  (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  )
  else
    $error("grant has more than one port set: %h", grant);

  // a port is granted only after it requested in the cycle before
  grantNeedsRequest: assert property
  (
    @(posedge clk) disable iff (rst)
    (grant & ~$past(req)) == '0
  )
  else
    $error("grant %h given to a port without a request", grant);

  // a spent budget releases the owner on the next edge
  expiredGrantDrops: assert property
  (
    @(posedge clk) disable iff (rst)
    ((grant & timesUp) != '0) |=> ((grant & $past(grant & timesUp)) == '0)
  )
  else
    $error("owner kept the grant after its budget ran out: %h", grant);

endmodule

/* hdl/outputArbiter.sv */
`timescale 1ns/1ps

module outputArbiter
(
  input  logic                                            clk,
  input  logic                                            rst,
  input  routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] portFlits,
  output routerPkg::portVec_t                             grant
);

  routerPkg::portVec_t req;       // open packets per port
  routerPkg::portVec_t timesUp;
  routerPkg::portVec_t runTimer;  // owner's timer enable

  requestTracker requestTracker_i
  (
    .clk       (clk),
    .rst       (rst),
    .portFlits (portFlits),
    .req       (req)
  );

  grantTimers grantTimers_i
  (
    .clk       (clk),
    .rst       (rst),
    .portFlits (portFlits),
    .runTimer  (runTimer),
    .timesUp   (timesUp)
  );

  // combines requests and budgets into the grant
  grantArbiter grantArbiter_i
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant)
  );

endmodule

/* hdl/grantArbiter.sv */
`timescale 1ns/1ps

module grantArbiter
(
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::portVec_t req,
  input  routerPkg::portVec_t timesUp,
  output routerPkg::portVec_t runTimer,
  output routerPkg::portVec_t grant
);

  routerPkg::arbState_t state;
  routerPkg::arbState_t nextState;
  int unsigned          ownerIdx;    // port named by the current state
  logic                 ownerValid;  // low in idle
  logic                 holdGrant;
  routerPkg::portVec_t  otherReq;    // requests with the owner masked out

  // state code of port p
  function automatic routerPkg::arbState_t portState(input int unsigned p);
    logic [5:0] code;
    code = 6'b000010 << p;
    return routerPkg::arbState_t'(code);
  endfunction

  // first requester met when walking the ports in rotation from first
  function automatic routerPkg::arbState_t pickFrom
  (
    input routerPkg::portVec_t reqs,
    input int unsigned         first
  );
    routerPkg::arbState_t pick;
    logic                 found;
    int unsigned          p;
    pick  = routerPkg::ARB_IDLE;
    found = 1'b0;
    p     = first;
    for (int i = 0; i < routerPkg::NUM_PORTS; i++)
    begin
      if (!found && reqs[p])
      begin
        pick  = portState(p);
        found = 1'b1;
      end
      p = (p + 1) % routerPkg::NUM_PORTS;
    end
    return pick;
  endfunction

  // decode the owner from the one-hot state
  always_comb
  begin
    ownerValid = 1'b1;
    ownerIdx   = 0;
    case (state)
      routerPkg::ARB_LOCAL:
        ownerIdx = 0;
      routerPkg::ARB_NORTH:
        ownerIdx = 1;
      routerPkg::ARB_EAST:
        ownerIdx = 2;
      routerPkg::ARB_WEST:
        ownerIdx = 3;
      routerPkg::ARB_SOUTH:
        ownerIdx = 4;
      default:
        ownerValid = 1'b0;  // idle, or a broken code
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    otherReq  = req;
    holdGrant = ownerValid && req[ownerIdx] && !timesUp[ownerIdx];
    if (!ownerValid)
    begin
      // fixed order from idle, Local first
      nextState = pickFrom(req, 0);
    end
    else if (holdGrant)
    begin
      nextState          = state;
      runTimer[ownerIdx] = 1'b1;
    end
    else
    begin
      // tail seen or budget spent, hand over after the owner
      otherReq[ownerIdx] = 1'b0;
      nextState          = pickFrom(otherReq, (ownerIdx + 1) % routerPkg::NUM_PORTS);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::ARB_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[routerPkg::NUM_PORTS:1];  // drop the idle bit

endmodule

/* hdl/grantTimers.sv */
`timescale 1ns/1ps

module grantTimers
(
  input  logic                                            clk,
  input  logic                                            rst,
  input  routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] portFlits,
  input  routerPkg::portVec_t                             runTimer,
  output routerPkg::portVec_t                             timesUp
);

  for (genvar p = 0; p < routerPkg::NUM_PORTS; p++)
  begin : genTimer

    routerPkg::pktLength_t budget;  // cycles the grant may last, minus one
    routerPkg::pktLength_t count;
    logic                  loadBudget;

    assign loadBudget = portFlits[p].valid &&
                        (portFlits[p].flitId == routerPkg::FLIT_HEADER);

    // only a header carries a length, body flits leave the budget alone
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        budget <= '0;
      end
      else if (loadBudget)
      begin
        budget <= portFlits[p].length;
      end
    end

    // counts while the arbiter holds this port, restarts otherwise
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        count <= '0;
      end
      else if (runTimer[p])
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end

    assign timesUp[p] = (count == budget);  // count runs 0..budget

  end

endmodule

/* hdl/requestTracker.sv */
`timescale 1ns/1ps

module requestTracker
(
  input  logic                                            clk,
  input  logic                                            rst,
  input  routerPkg::portFlit_t [routerPkg::NUM_PORTS-1:0] portFlits,
  output routerPkg::portVec_t                             req
);

  routerPkg::portVec_t isHeader;
  routerPkg::portVec_t isTail;

  // decode the flit kind of each port, only valid flits count
  always_comb
  begin
    for (int p = 0; p < routerPkg::NUM_PORTS; p++)
    begin
      isHeader[p] = portFlits[p].valid &&
                    (portFlits[p].flitId == routerPkg::FLIT_HEADER);
      isTail[p]   = portFlits[p].valid &&
                    (portFlits[p].flitId == routerPkg::FLIT_TAIL);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req <= '0;
    end
    else
    begin
      for (int p = 0; p < routerPkg::NUM_PORTS; p++)
      begin
        if (isHeader[p])
          req[p] <= 1'b1;  // packet opens
        else if (isTail[p])
          req[p] <= 1'b0;
        // body flits and idle cycles keep the level
      end
    end
  end

endmodule

/* hdl/routerPkg.sv */
package routerPkg;

  // port order is Local, North, East, West, South (index 0 to 4)
  localparam int unsigned NUM_PORTS = 5;

  // flit kind as carried in the flit header field
  typedef logic [2:0] flitId_t;

  localparam flitId_t FLIT_HEADER = 3'd1;
  localparam flitId_t FLIT_BODY   = 3'd2;
  localparam flitId_t FLIT_TAIL   = 3'd3;

  // packet length, doubles as the grant budget in cycles
  typedef logic [11:0] pktLength_t;

  // one bit per port, index as in the port order above
  typedef logic [NUM_PORTS-1:0] portVec_t;

  typedef struct packed
  {
    logic       valid;
    flitId_t    flitId;
    pktLength_t length;  // only meaningful on a header flit
  } portFlit_t;

  // one-hot arbiter state, bit 0 is idle and bit p+1 is port p
  typedef enum logic [5:0]
  {
    ARB_IDLE  = 6'b000001,
    ARB_LOCAL = 6'b000010,
    ARB_NORTH = 6'b000100,
    ARB_EAST  = 6'b001000,
    ARB_WEST  = 6'b010000,
    ARB_SOUTH = 6'b100000
  } arbState_t;

endpackage
